/* test/lsu_input.txt */
# op base offset st_data dest exp_data exp_we exp_ale, all hex, one instruction per line
# op: 0 addr, 1 ld_b, 2 ld_bu, 3 ld_h, 4 ld_hu, 5 ld_w, 6 st_b, 7 st_h, 8 st_w
8 00000100 00000000 8765f0a1 01 00000100 0 0
5 00000100 00000000 00000000 02 8765f0a1 1 0
1 00000100 00000000 00000000 03 ffffffa1 1 0
1 00000100 00000001 00000000 04 fffffff0 1 0
1 00000100 00000002 00000000 05 00000065 1 0
1 00000100 00000003 00000000 06 ffffff87 1 0
2 00000100 00000000 00000000 07 000000a1 1 0
2 00000100 00000001 00000000 08 000000f0 1 0
2 00000100 00000002 00000000 09 00000065 1 0
2 00000100 00000003 00000000 0a 00000087 1 0
3 00000100 00000000 00000000 0b fffff0a1 1 0
3 00000100 00000002 00000000 0c ffff8765 1 0
4 00000100 00000000 00000000 0d 0000f0a1 1 0
4 00000100 00000002 00000000 0e 00008765 1 0
5 00000200 00000000 00000000 0f 00000000 1 0
6 00000200 00000001 123456ab 10 00000201 0 0
7 00000200 00000002 cafe7c3d 11 00000202 0 0
5 00000200 00000000 00000000 12 7c3dab00 1 0
6 000001fc 00000007 eeeeee99 13 00000203 0 0
5 00000200 00000000 00000000 14 993dab00 1 0
3 00000200 00000002 00000000 15 ffff993d 1 0
4 00000200 00000002 00000000 16 0000993d 1 0
1 00000200 00000001 00000000 17 ffffffab 1 0
3 00000300 00000001 00000000 18 00000301 0 1
5 00000300 00000002 00000000 19 00000302 0 1
8 00000100 00000001 11111111 1a 00000101 0 1
7 00000100 00000003 22222222 1b 00000103 0 1
5 00000100 00000000 00000000 1c 8765f0a1 1 0
0 12345678 00000010 00000000 1d 12345688 1 0
0 fffffff0 00000020 00000000 1e 00000010 1 0
4 00000300 00000000 00000000 1f 00000000 1 0
8 000003fc 00000000 13579bdf 00 000003fc 0 0
3 00000400 fffffffe 00000000 01 00001357 1 0
1 000003fc 00000000 00000000 02 ffffffdf 1 0
2 000003fc 00000002 00000000 03 00000057 1 0
7 000003fc 00000000 00008001 04 000003fc 0 0
5 000003fc 00000000 00000000 05 13578001 1 0
3 000003fc 00000000 00000000 06 ffff8001 1 0

/* build.f */
design/lsu_pkg.sv
design/lsu_addr_stage.sv
design/lsu_mem_stage.sv
design/lsu_wb_stage.sv
design/lsu_pipe.sv
test/lsu_pipe_props.sv
test/lsu_pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the LSU pipeline testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f build.f --top-module lsu_pipe_tb -o lsu_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_pipe_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if [ "$sim_status" -eq 0 ] && grep -qx "TESTBENCH PASSED" "$log"; then
    exit 0
fi
echo "simulation failed with status $sim_status"
exit 1

/* test/lsu_pipe_tb.sv */
`timescale 1ns/1ps

module lsu_pipe_tb import lsu_pkg::*; ();

    localparam int clk_period     = 100; // ns.
    localparam int max_addr_delay = 2;   // cycles before mem_addr_ok rises.
    localparam int max_resp_delay = 4;   // cycles from acceptance to mem_data_ok.

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    lsu_inst_t       in_inst;
    logic            in_ready;
    logic            mem_req;
    lsu_mem_req_t    mem_req_data;
    logic            mem_addr_ok;
    logic            mem_data_ok;
    logic [xlen-1:0] mem_rdata;
    logic            commit_valid;
    lsu_commit_t     commit;
    logic [xlen-1:0] bad_addr;
    logic            bad_addr_valid;

    lsu_inst_t       vec_inst[$];
    lsu_commit_t     vec_exp[$];
    lsu_commit_t     exp_q[$];          // results of accepted instructions, in issue order.
    logic [xlen-1:0] data_mem [0:255];
    integer          seed;
    int              num_vec;
    int              commit_count;
    logic            started;
    logic            bad_seen;
    logic [xlen-1:0] bad_exp;

    lsu_pipe i_dut (.*);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_commit(input lsu_commit_t got, input lsu_commit_t want);
        if (got !== want) begin
            abort_run({$sformatf("ERR %0t commit: expected dest=%0d we=%0b data=%h ale=%0b, ",
                                 $time, want.dest, want.we, want.data, want.ex_ale),
                       $sformatf("got dest=%0d we=%0b data=%h ale=%0b",
                                 got.dest, got.we, got.data, got.ex_ale)});
        end
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("ERR %0t %s: expected %h, got %h", $time, name, want, got));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("ERR %0t %s: expected %0b, got %0b", $time, name, want, got));
        end
    endtask

    // Each data line holds op, base, offset, store data, dest and the expected
    // commit data, write enable and exception flag, all in hex.
    task automatic load_vectors();
        int              fd;
        int              n;
        string           line;
        logic [3:0]      op;
        logic [xlen-1:0] base;
        logic [xlen-1:0] offset;
        logic [xlen-1:0] sdata;
        logic [xlen-1:0] exp_data;
        logic [4:0]      dest;
        logic            we;
        logic            ale;
        lsu_inst_t       inst;
        lsu_commit_t     want;
        fd = $fopen("test/lsu_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file test/lsu_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = 0;
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                op, base, offset, sdata, dest, exp_data, we, ale);
                end
                if (n == 8) begin
                    inst.op         = lsu_op_e'(op);
                    inst.base       = base;
                    inst.offset     = offset;
                    inst.store_data = sdata;
                    inst.dest       = dest;
                    want.dest       = dest;
                    want.we         = we;
                    want.data       = exp_data;
                    want.ex_ale     = ale;
                    vec_inst.push_back(inst);
                    vec_exp.push_back(want);
                end
            end
            $fclose(fd);
            num_vec = vec_inst.size();
        end
    endtask

    initial begin : make_clock
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin : run_test
        rst_n        = 1'b0;
        started      = 1'b0;
        seed         = 59;
        commit_count = 0;
        bad_seen     = 1'b0;
        bad_exp      = '0;
        $timeformat(-9, 0, " ns", 0);
        load_vectors();
        if (num_vec == 0) begin
            abort_run("the stimulus file holds no instructions");
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("in_ready", in_ready, 1'b1); // idle pipeline state while in reset.
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("addr_to_mem_valid", i_dut.addr_to_mem_valid, 1'b0);
        check_bit("mem_to_wb_valid", i_dut.mem_to_wb_valid, 1'b0);
        check_bit("commit_valid", commit_valid, 1'b0);
        check_bit("bad_addr_valid", bad_addr_valid, 1'b0);
        @(posedge clk);
        #1;
        rst_n   = 1'b1;
        started = 1'b1;
        wait (commit_count == num_vec);
        repeat (10) @(posedge clk); // any late extra commit is caught by the monitor.
        @(negedge clk);
        if (in_ready && !mem_req) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("the pipeline did not drain after the last commit");
        end
    end

    // Decisions are taken at the falling edge and driven 1 ns after the rising one.
    initial begin : drive_inputs
        int unsigned idx;
        logic        send;
        in_valid = 1'b0;
        in_inst  = '0;
        idx      = 0;
        wait (started);
        forever begin
            @(negedge clk);
            if (in_valid && in_ready) begin
                exp_q.push_back(vec_exp[idx]);
                idx++;
            end
            send = in_valid && !in_ready; // an offer stays until it is taken.
            if (!send && idx < num_vec) begin
                send = ($unsigned($random(seed)) % 5) != 0;
            end
            @(posedge clk);
            #1;
            in_valid = send;
            if (send) begin
                in_inst = vec_inst[idx];
            end
        end
    end

    initial begin : memory_model
        int               addr_wait;
        int               resp_wait;
        logic             accept;
        logic             stalled;
        lsu_mem_req_t     req;
        logic [xlen-1:0]  resp_word;
        logic [7:0]       widx;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        addr_wait   = 0;
        resp_wait   = 0;
        resp_word   = '0;
        for (int i = 0; i < 256; i++) begin
            data_mem[i] = '0;
        end
        forever begin
            @(negedge clk);
            accept  = rst_n && mem_req && mem_addr_ok;
            stalled = rst_n && mem_req && !mem_addr_ok;
            req     = mem_req_data;
            @(posedge clk);
            #1;
            mem_data_ok = 1'b0;
            if (accept) begin
                widx = req.addr[9:2];
                for (int b = 0; b < 4; b++) begin
                    if (req.wr && req.wstrb[b]) begin
                        data_mem[widx][8*b +: 8] = req.wdata[8*b +: 8];
                    end
                end
                resp_word = data_mem[widx];
                resp_wait = 1 + $unsigned($random(seed)) % max_resp_delay;
                addr_wait = $unsigned($random(seed)) % (max_addr_delay + 1);
            end else if (stalled && addr_wait > 0) begin
                addr_wait--;
            end
            if (resp_wait > 0) begin
                resp_wait--;
                if (resp_wait == 0) begin
                    mem_data_ok = 1'b1; // a single cycle of response.
                    mem_rdata   = resp_word;
                end
            end
            mem_addr_ok = (addr_wait == 0);
        end
    end

    initial begin : watch_commits
        lsu_commit_t want;
        forever begin
            @(negedge clk);
            if (rst_n && commit_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("a commit appeared with no instruction in flight");
                end else begin
                    want = exp_q.pop_front();
                    check_commit(commit, want);
                    commit_count++;
                    if (want.ex_ale && !bad_seen) begin
                        bad_seen = 1'b1;
                        bad_exp  = want.data; // only the first misaligned address sticks.
                    end
                end
            end
            if (rst_n) begin
                check_bit("bad_addr_valid", bad_addr_valid, bad_seen);
                if (bad_seen) begin
                    check_word("bad_addr", bad_addr, bad_exp);
                end
            end
        end
    end

    initial begin : watchdog
        wait (started);
        repeat (num_vec * 20 + 100) @(posedge clk);
        abort_run($sformatf("timeout: only %0d of %0d instructions committed in time",
                            commit_count, num_vec));
    end

endmodule

/* test/lsu_pipe_props.sv */
`timescale 1ns/1ps

module lsu_pipe_props import lsu_pkg::*; (
    input logic         clk,
    input logic         rst_n,
    input logic         in_valid,
    input lsu_inst_t    in_inst,
    input logic         in_ready,
    input logic         mem_req,
    input lsu_mem_req_t mem_req_data,
    input logic         mem_addr_ok,
    input logic         mem_data_ok,
    input logic         commit_valid
);

    logic outstanding; // an accepted request still owes its response.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            outstanding <= 1'b1;
        end else if (mem_data_ok) begin
            outstanding <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_req_data))
        else $error("memory request dropped or changed before mem_addr_ok");

    resp_owed: assert property (@(posedge clk) disable iff (!rst_n)
        mem_data_ok |-> outstanding)
        else $error("mem_data_ok without an outstanding request");

    // The previous response may arrive on the same edge as the next acceptance.
    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && mem_addr_ok |-> !outstanding || mem_data_ok)
        else $error("second memory request accepted while one is outstanding");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !commit_valid && !mem_req)
        else $error("commit_valid or mem_req high during reset");

    in_held: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_inst))
        else $error("instruction offer changed before in_ready");

endmodule

bind lsu_pipe lsu_pipe_props i_props (.*);

/* design/lsu_pipe.sv */
`timescale 1ns/1ps

module lsu_pipe import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            in_valid,
    input  lsu_inst_t       in_inst,
    output logic            in_ready,

    output logic            mem_req,
    output lsu_mem_req_t    mem_req_data,
    input  logic            mem_addr_ok,
    input  logic            mem_data_ok,
    input  logic [xlen-1:0] mem_rdata,

    output logic            commit_valid,
    output lsu_commit_t     commit,
    output logic [xlen-1:0] bad_addr,
    output logic            bad_addr_valid
);

    logic        addr_to_mem_valid;
    lsu_to_mem_t addr_to_mem_data;
    logic        mem_allow_in;
    logic        mem_to_wb_valid;
    lsu_commit_t mem_to_wb_data;
    logic        wb_allow_in;

    lsu_addr_stage i_addr_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .in_ready     (in_ready),
        .out_valid    (addr_to_mem_valid),
        .out_data     (addr_to_mem_data),
        .mem_allow_in (mem_allow_in),
        .mem_req      (mem_req),
        .mem_req_data (mem_req_data),
        .mem_addr_ok  (mem_addr_ok)
    );

    lsu_mem_stage i_mem_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (addr_to_mem_valid),
        .in_data     (addr_to_mem_data),
        .allow_in    (mem_allow_in),
        .out_valid   (mem_to_wb_valid),
        .out_data    (mem_to_wb_data),
        .wb_allow_in (wb_allow_in),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    lsu_wb_stage i_wb_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (mem_to_wb_valid),
        .in_data        (mem_to_wb_data),
        .allow_in       (wb_allow_in),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .bad_addr       (bad_addr),
        .bad_addr_valid (bad_addr_valid)
    );

endmodule

/* design/lsu_wb_stage.sv */
`timescale 1ns/1ps

module lsu_wb_stage import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            in_valid,
    input  lsu_commit_t     in_data,
    output logic            allow_in,

    output logic            commit_valid,
    output lsu_commit_t     commit,

    output logic [xlen-1:0] bad_addr,
    output logic            bad_addr_valid
);

    logic        valid;
    lsu_commit_t commit_r;

    // Retirement takes one cycle and never stalls.
    assign allow_in = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            commit_r <= in_data;
        end
    end

    // Only the first misaligned address is kept.
    // It becomes visible in the same cycle the access commits.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bad_addr_valid <= 1'b0;
            bad_addr       <= '0;
        end else if (in_valid && in_data.ex_ale && !bad_addr_valid) begin
            bad_addr_valid <= 1'b1;
            bad_addr       <= in_data.data; // the memory stage passes the address as data.
        end
    end

    assign commit_valid = valid;
    assign commit       = commit_r;

endmodule

/* design/lsu_mem_stage.sv */
`timescale 1ns/1ps

module lsu_mem_stage import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            in_valid,
    input  lsu_to_mem_t     in_data,
    output logic            allow_in,

    output logic            out_valid,
    output lsu_commit_t     out_data,
    input  logic            wb_allow_in,

    input  logic            mem_data_ok,
    input  logic [xlen-1:0] mem_rdata
);

    logic            valid;
    logic            ready_go;
    lsu_to_mem_t     data_r;
    logic            data_ok_r;  // response already taken while blocked.
    logic [xlen-1:0] rdata_r;
    logic [xlen-1:0] rdata;
    logic            is_load;
    logic            is_signed;
    logic            is_byte;
    logic            is_half;
    logic [7:0]      lane_b;
    logic [15:0]     lane_h;
    logic [xlen-1:0] ext_b;
    logic [xlen-1:0] ext_h;
    logic [xlen-1:0] load_data;

    assign ready_go  = !data_r.mem_en || mem_data_ok || data_ok_r;
    assign allow_in  = !valid || (ready_go && wb_allow_in);
    assign out_valid = valid && ready_go;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (allow_in) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allow_in) begin
            data_r <= in_data;
        end
    end

    // Keep a response that arrives while the writeback stage holds us off.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_ok_r <= 1'b0;
        end else if (out_valid && wb_allow_in) begin
            data_ok_r <= 1'b0; // the entry leaves, so the held response goes with it.
        end else if (valid && data_r.mem_en && mem_data_ok) begin
            data_ok_r <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && data_r.mem_en && mem_data_ok && !data_ok_r) begin
            rdata_r <= mem_rdata;
        end
    end

    assign rdata = data_ok_r ? rdata_r : mem_rdata;

    assign is_load   = data_r.op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    assign is_signed = data_r.op inside {op_ld_b, op_ld_h};
    assign is_byte   = data_r.op inside {op_ld_b, op_ld_bu};
    assign is_half   = data_r.op inside {op_ld_h, op_ld_hu};

    always_comb begin
        case (data_r.addr[1:0])
            2'b00:   lane_b = rdata[7:0];
            2'b01:   lane_b = rdata[15:8];
            2'b10:   lane_b = rdata[23:16];
            default: lane_b = rdata[31:24];
        endcase
    end

    // An aligned halfword sits in the low or the high half.
    assign lane_h = data_r.addr[1] ? rdata[31:16] : rdata[15:0];

    assign ext_b = is_signed ? {{24{lane_b[7]}}, lane_b} : {24'b0, lane_b};
    assign ext_h = is_signed ? {{16{lane_h[15]}}, lane_h} : {16'b0, lane_h};

    assign load_data = is_byte ? ext_b :
                       is_half ? ext_h :
                                 rdata;

    assign out_data.dest   = data_r.dest;
    assign out_data.ex_ale = data_r.ex_ale;
    assign out_data.we     = (is_load || data_r.op == op_addr) && !data_r.ex_ale;
    // Misaligned accesses, stores and op_addr report the address.
    assign out_data.data   = (is_load && !data_r.ex_ale) ? load_data : data_r.addr;

endmodule

/* design/lsu_addr_stage.sv */
`timescale 1ns/1ps

module lsu_addr_stage import lsu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,

    input  logic         in_valid,
    input  lsu_inst_t    in_inst,
    output logic         in_ready,

    output logic         out_valid,
    output lsu_to_mem_t  out_data,
    input  logic         mem_allow_in,

    output logic         mem_req,
    output lsu_mem_req_t mem_req_data,
    input  logic         mem_addr_ok
);

    logic            valid;
    logic            ready_go;
    lsu_inst_t       inst_r;
    logic [xlen-1:0] addr;
    logic            is_load;
    logic            is_store;
    logic            is_half;
    logic            is_word;
    logic            ex_ale;
    logic            need_mem;
    logic [3:0]      wstrb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (in_ready) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            inst_r <= in_inst;
        end
    end

    assign addr     = inst_r.base + inst_r.offset;
    assign is_load  = inst_r.op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    assign is_store = inst_r.op inside {op_st_b, op_st_h, op_st_w};
    assign is_half  = inst_r.op inside {op_ld_h, op_ld_hu, op_st_h};
    assign is_word  = inst_r.op inside {op_ld_w, op_st_w};

    // Halfwords need an even address, words a multiple of four.
    assign ex_ale   = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));
    assign need_mem = (is_load || is_store) && !ex_ale;

    always_comb begin
        case (inst_r.op)
            op_st_b: wstrb = 4'b0001 << addr[1:0];
            op_st_h: wstrb = 4'b0011 << addr[1:0];
            op_st_w: wstrb = 4'b1111;
            default: wstrb = 4'b0000; // loads write nothing.
        endcase
    end

    // The request only goes out when the memory stage can take the entry on the
    // same edge, so a raised request is never withdrawn.
    assign mem_req            = valid && need_mem && mem_allow_in;
    assign mem_req_data.addr  = addr;
    assign mem_req_data.wr    = is_store;
    assign mem_req_data.wstrb = wstrb;
    assign mem_req_data.wdata = inst_r.store_data << {addr[1:0], 3'b000};

    assign ready_go  = !need_mem || (mem_req && mem_addr_ok);
    assign in_ready  = !valid || (ready_go && mem_allow_in);
    assign out_valid = valid && ready_go;

    assign out_data.op     = inst_r.op;
    assign out_data.addr   = addr;
    assign out_data.dest   = inst_r.dest;
    assign out_data.ex_ale = ex_ale;
    assign out_data.mem_en = need_mem; // misaligned and address-only ops skip memory.

endmodule

/* design/lsu_pkg.sv */
package lsu_pkg;

    localparam int xlen       = 32; // data and address width.
    localparam int reg_addr_w = 5;  // destination register index width.

    // Operations handled by the load/store back end.
    // The encodings are fixed because the stimulus file gives op as a number.
    typedef enum logic [3:0] {
        op_addr  = 4'd0,
        op_ld_b  = 4'd1,
        op_ld_bu = 4'd2,
        op_ld_h  = 4'd3,
        op_ld_hu = 4'd4,
        op_ld_w  = 4'd5,
        op_st_b  = 4'd6,
        op_st_h  = 4'd7,
        op_st_w  = 4'd8
    } lsu_op_e;

    // A decoded instruction with its base register already read out.
    typedef struct packed {
        lsu_op_e                 op;
        logic [xlen-1:0]         base;
        logic [xlen-1:0]         offset;
        logic [xlen-1:0]         store_data; // only meaningful for stores.
        logic [reg_addr_w-1:0]   dest;
    } lsu_inst_t;

    // Request sent to the data memory.
    typedef struct packed {
        logic [xlen-1:0]         addr;
        logic                    wr;    // high for stores.
        logic [3:0]              wstrb; // one bit per byte lane.
        logic [xlen-1:0]         wdata; // already shifted into the addressed lanes.
    } lsu_mem_req_t;

    // Payload from the address stage to the memory stage.
    typedef struct packed {
        lsu_op_e                 op;
        logic [xlen-1:0]         addr;
        logic [reg_addr_w-1:0]   dest;
        logic                    ex_ale; // misaligned access.
        logic                    mem_en; // a memory response is owed to this entry.
    } lsu_to_mem_t;

    // Retired result, also used between the memory and writeback stages.
    typedef struct packed {
        logic [reg_addr_w-1:0]   dest;
        logic                    we;
        logic [xlen-1:0]         data;
        logic                    ex_ale;
    } lsu_commit_t;

endpackage
